/* core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// datapath and address width
`define CORE_XLEN     32

// register file
`define CORE_NREGS    32
`define CORE_REG_AW   5

// first fetch address out of reset
`define CORE_RESET_PC 32'h0000_0000

// architectural register mirrored on gp
`define CORE_GP_REG   3

`endif

/* core_pkg.sv */
package core_pkg;

    // rv32i major opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC_PLUS4
    } wb_sel_e;

    // decoded control, travels down the pipe
    typedef struct packed {
        alu_op_e alu_op;
        wb_sel_e wb_sel;
        logic    rf_wen;
        logic    mem_wen;
        logic    mem_ren;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jal;
        logic    is_ecall;
        logic    valid;
    } ctrl_t;

endpackage

/* stage_if.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

// decode -> execute register
interface decode_exec_if;
    core_pkg::ctrl_t         ctrl;
    logic [`CORE_XLEN-1:0]   pc;
    logic [`CORE_XLEN-1:0]   op1;
    logic [`CORE_XLEN-1:0]   op2;
    logic [`CORE_XLEN-1:0]   rs2_data;
    logic [`CORE_XLEN-1:0]   imm;
    logic [`CORE_REG_AW-1:0] rd;

    modport src (output ctrl, pc, op1, op2, rs2_data, imm, rd);
    modport dst (input ctrl, pc, op1, op2, rs2_data, imm, rd);
endinterface

// execute -> memory register
interface exec_mem_if;
    core_pkg::ctrl_t         ctrl;
    logic [`CORE_XLEN-1:0]   pc;
    logic [`CORE_XLEN-1:0]   alu_out;
    logic [`CORE_XLEN-1:0]   rs2_data;
    logic [`CORE_REG_AW-1:0] rd;
    logic                    br_taken;
    logic [`CORE_XLEN-1:0]   br_target;

    modport src (output ctrl, pc, alu_out, rs2_data, rd, br_taken, br_target);
    modport dst (input ctrl, pc, alu_out, rs2_data, rd, br_taken, br_target);
endinterface

// memory -> writeback register
interface mem_wb_if;
    core_pkg::ctrl_t         ctrl;
    logic [`CORE_XLEN-1:0]   pc;
    logic [`CORE_XLEN-1:0]   alu_out;
    logic [`CORE_XLEN-1:0]   rdata;
    logic [`CORE_REG_AW-1:0] rd;
    logic                    br_taken;
    logic [`CORE_XLEN-1:0]   br_target;

    modport src (output ctrl, pc, alu_out, rdata, rd, br_taken, br_target);
    modport dst (input ctrl, pc, alu_out, rdata, rd, br_taken, br_target);
endinterface

/* fetch_stage.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module fetch_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  hazard_stall,
    input  logic                  flush,
    input  logic [`CORE_XLEN-1:0] redirect_pc,
    input  logic                  halt,
    output logic                  inst_start,
    output logic [`CORE_XLEN-1:0] i_addr,
    input  logic                  inst_ready,
    input  logic [`CORE_XLEN-1:0] inst,
    input  logic                  inst_valid,
    output logic                  id_valid,
    output logic [`CORE_XLEN-1:0] id_pc,
    output logic [`CORE_XLEN-1:0] id_inst
);

    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] fetch_pc;
    logic                  pending;
    logic                  drop;
    logic                  advance;
    logic                  id_free;
    logic                  word_in;
    logic                  issue;

    assign advance  = !stall && !hazard_stall;
    // fetch register is empty after this edge
    assign id_free  = flush || !id_valid || advance;
    assign word_in  = pending && inst_valid && !drop && !flush;
    // one request in flight, and only into an empty slot
    assign issue    = !inst_start && !pending && id_free && !halt;
    assign fetch_pc = flush ? redirect_pc : pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= `CORE_RESET_PC;
            inst_start <= 1'b0;
            pending    <= 1'b0;
            drop       <= 1'b0;
            id_valid   <= 1'b0;
        end else begin
            if (issue) begin
                inst_start <= 1'b1;
                pc         <= fetch_pc + 32'd4;
            end else begin
                if (flush)
                    pc <= redirect_pc;
                // a halt withdraws a request not yet taken
                if (inst_ready || halt)
                    inst_start <= 1'b0;
            end

            if (inst_start && inst_ready)
                pending <= 1'b1;
            else if (inst_valid)
                pending <= 1'b0;

            // word still in flight belongs to the old path
            if (flush && (inst_start || (pending && !inst_valid)))
                drop <= 1'b1;
            else if (pending && inst_valid)
                drop <= 1'b0;

            if (flush)
                id_valid <= 1'b0;
            else if (word_in)
                id_valid <= 1'b1;
            else if (advance)
                id_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue)
            i_addr <= fetch_pc;
        if (word_in) begin
            id_pc   <= i_addr;
            id_inst <= inst;
        end
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    id_valid,
    input  logic [`CORE_XLEN-1:0]   id_pc,
    input  logic [`CORE_XLEN-1:0]   id_inst,
    input  logic                    stall,
    input  logic                    flush,
    output logic [`CORE_REG_AW-1:0] rs1_addr,
    output logic [`CORE_REG_AW-1:0] rs2_addr,
    input  logic [`CORE_XLEN-1:0]   rs1_data,
    input  logic [`CORE_XLEN-1:0]   rs2_data,
    output logic                    hazard_stall,
    input  logic [`CORE_REG_AW-1:0] ex_rd,
    input  logic                    ex_rf_wen,
    input  logic [`CORE_REG_AW-1:0] mem_rd,
    input  logic                    mem_rf_wen,
    input  logic [`CORE_REG_AW-1:0] wb_rd,
    input  logic                    wb_rf_wen,
    decode_exec_if.src              de
);

    core_pkg::ctrl_t       ctrl;
    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] imm_s;
    logic [`CORE_XLEN-1:0] imm_b;
    logic [`CORE_XLEN-1:0] imm_j;
    logic [`CORE_XLEN-1:0] imm_u;
    logic [`CORE_XLEN-1:0] imm;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  rs1_busy;
    logic                  rs2_busy;

    function automatic core_pkg::alu_op_e alu_func(input logic [2:0] funct3,
                                                   input logic       sub);
        core_pkg::alu_op_e op;
        case (funct3)
            3'b000: begin
                if (sub)
                    op = core_pkg::ALU_SUB;
                else
                    op = core_pkg::ALU_ADD;
            end
            3'b010:  op = core_pkg::ALU_SLT;
            3'b100:  op = core_pkg::ALU_XOR;
            3'b110:  op = core_pkg::ALU_OR;
            3'b111:  op = core_pkg::ALU_AND;
            default: op = core_pkg::ALU_ADD;
        endcase
        return op;
    endfunction

    assign rs1_addr = id_inst[19:15];
    assign rs2_addr = id_inst[24:20];

    // ******************************
    // immediates
    // ******************************
    assign imm_i = {{20{id_inst[31]}}, id_inst[31:20]};
    assign imm_s = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
    assign imm_b = {{19{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                    id_inst[11:8], 1'b0};
    assign imm_j = {{11{id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
                    id_inst[30:21], 1'b0};
    assign imm_u = {id_inst[31:12], 12'b0};

    always_comb begin
        ctrl       = '0;
        ctrl.valid = id_valid;
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        imm        = imm_i;
        case (id_inst[6:0])
            core_pkg::OPC_OP: begin
                ctrl.rf_wen = 1'b1;
                ctrl.alu_op = alu_func(id_inst[14:12], id_inst[30]);
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
            end
            core_pkg::OPC_OP_IMM: begin
                ctrl.rf_wen = 1'b1;
                ctrl.alu_op = alu_func(id_inst[14:12], 1'b0);
                use_rs1     = 1'b1;
            end
            core_pkg::OPC_LUI: begin
                ctrl.rf_wen = 1'b1;
                ctrl.alu_op = core_pkg::ALU_PASS_B;
                imm         = imm_u;
            end
            core_pkg::OPC_LOAD: begin
                ctrl.rf_wen  = 1'b1;
                ctrl.mem_ren = 1'b1;
                ctrl.wb_sel  = core_pkg::WB_MEM;
                use_rs1      = 1'b1;
            end
            core_pkg::OPC_STORE: begin
                ctrl.mem_wen = 1'b1;
                use_rs1      = 1'b1;
                use_rs2      = 1'b1;
                imm          = imm_s;
            end
            core_pkg::OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = id_inst[12];
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                imm            = imm_b;
            end
            core_pkg::OPC_JAL: begin
                ctrl.is_jal = 1'b1;
                ctrl.rf_wen = 1'b1;
                ctrl.wb_sel = core_pkg::WB_PC_PLUS4;
                imm         = imm_j;
            end
            core_pkg::OPC_SYSTEM: ctrl.is_ecall = (id_inst[31:7] == '0);
            default: ;
        endcase
    end

    // no forwarding, wait until the writer has left writeback
    assign rs1_busy = (rs1_addr != '0) &&
                      ((ex_rf_wen && ex_rd == rs1_addr) ||
                       (mem_rf_wen && mem_rd == rs1_addr) ||
                       (wb_rf_wen && wb_rd == rs1_addr));
    assign rs2_busy = (rs2_addr != '0) &&
                      ((ex_rf_wen && ex_rd == rs2_addr) ||
                       (mem_rf_wen && mem_rd == rs2_addr) ||
                       (wb_rf_wen && wb_rd == rs2_addr));
    assign hazard_stall = id_valid && ((use_rs1 && rs1_busy) || (use_rs2 && rs2_busy));

    always_ff @(posedge clk) begin
        if (reset || flush)
            de.ctrl <= '0;
        else if (!stall) begin
            if (hazard_stall)
                de.ctrl <= '0;
            else
                de.ctrl <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            de.pc       <= id_pc;
            de.op1      <= rs1_data;
            de.op2      <= (id_inst[6:0] == core_pkg::OPC_OP) ? rs2_data : imm;
            de.rs2_data <= rs2_data;
            de.imm      <= imm;
            de.rd       <= id_inst[11:7];
        end
    end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module execute_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    flush,
    decode_exec_if.dst              de,
    exec_mem_if.src                 em,
    output logic [`CORE_REG_AW-1:0] ex_rd,
    output logic                    ex_rf_wen
);

    logic [`CORE_XLEN-1:0] alu_out;
    logic                  br_taken;

    always_comb begin
        case (de.ctrl.alu_op)
            core_pkg::ALU_ADD: alu_out = de.op1 + de.op2;
            core_pkg::ALU_SUB: alu_out = de.op1 - de.op2;
            core_pkg::ALU_AND: alu_out = de.op1 & de.op2;
            core_pkg::ALU_OR:  alu_out = de.op1 | de.op2;
            core_pkg::ALU_XOR: alu_out = de.op1 ^ de.op2;
            core_pkg::ALU_SLT: begin
                alu_out = {{(`CORE_XLEN-1){1'b0}}, ($signed(de.op1) < $signed(de.op2))};
            end
            default:           alu_out = de.op2;
        endcase
    end

    // beq/bne on equality, jal always taken
    assign br_taken = de.ctrl.is_jal ||
                      (de.ctrl.is_branch && ((de.op1 == de.rs2_data) != de.ctrl.branch_ne));

    assign ex_rd     = de.rd;
    assign ex_rf_wen = de.ctrl.valid && de.ctrl.rf_wen;

    always_ff @(posedge clk) begin
        if (reset || flush)
            em.ctrl <= '0;
        else if (!stall)
            em.ctrl <= de.ctrl;
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            em.pc        <= de.pc;
            em.alu_out   <= alu_out;
            em.rs2_data  <= de.rs2_data;
            em.rd        <= de.rd;
            em.br_taken  <= br_taken;
            em.br_target <= de.pc + de.imm;
        end
    end

endmodule

/* memory_stage.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module memory_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    exec_mem_if.dst                 em,
    mem_wb_if.src                   mw,
    output logic                    mem_stall,
    output logic                    d_cmd_start,
    output logic                    d_cmd_write,
    output logic [`CORE_XLEN-1:0]   d_addr,
    output logic [`CORE_XLEN-1:0]   wdata,
    output logic [`CORE_XLEN-1:0]   wmask,
    input  logic                    d_cmd_ready,
    input  logic [`CORE_XLEN-1:0]   rdata,
    input  logic                    rdata_valid,
    output logic [`CORE_REG_AW-1:0] mem_rd,
    output logic                    mem_rf_wen
);

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_CMD,
        MS_WAIT
    } mem_state_e;

    mem_state_e state;
    logic       mem_op;
    logic       done;

    assign mem_op = em.ctrl.valid && (em.ctrl.mem_ren || em.ctrl.mem_wen);
    // store ends on acceptance, load on returned data
    assign done   = (state == MS_CMD && d_cmd_ready && em.ctrl.mem_wen) ||
                    (state == MS_WAIT && rdata_valid);
    assign mem_stall = mem_op && !done;

    // command fields come straight from the held pipeline register
    assign d_cmd_start = (state == MS_CMD);
    assign d_cmd_write = em.ctrl.mem_wen;
    assign d_addr      = em.alu_out;
    assign wdata       = em.rs2_data;
    assign wmask       = '1;

    assign mem_rd     = em.rd;
    assign mem_rf_wen = em.ctrl.valid && em.ctrl.rf_wen;

    always_ff @(posedge clk) begin
        if (reset)
            state <= MS_IDLE;
        else begin
            case (state)
                MS_IDLE: begin
                    if (mem_op && !flush)
                        state <= MS_CMD;
                end
                MS_CMD: begin
                    if (d_cmd_ready && em.ctrl.mem_wen)
                        state <= MS_IDLE;
                    else if (d_cmd_ready)
                        state <= MS_WAIT;
                end
                MS_WAIT: begin
                    if (rdata_valid)
                        state <= MS_IDLE;
                end
                default: state <= MS_IDLE;
            endcase
        end
    end

    // writeback sees a bubble while the data port is busy
    always_ff @(posedge clk) begin
        if (reset)
            mw.ctrl <= '0;
        else begin
            mw.ctrl       <= em.ctrl;
            mw.ctrl.valid <= em.ctrl.valid && !mem_stall && !flush;
        end
    end

    always_ff @(posedge clk) begin
        mw.pc        <= em.pc;
        mw.alu_out   <= em.alu_out;
        mw.rdata     <= rdata;
        mw.rd        <= em.rd;
        mw.br_taken  <= em.br_taken;
        mw.br_target <= em.br_target;
    end

endmodule

/* writeback_stage.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module writeback_stage (
    input  logic                    clk,
    input  logic                    reset,
    mem_wb_if.dst                   mw,
    input  logic [`CORE_REG_AW-1:0] rs1_addr,
    input  logic [`CORE_REG_AW-1:0] rs2_addr,
    output logic [`CORE_XLEN-1:0]   rs1_data,
    output logic [`CORE_XLEN-1:0]   rs2_data,
    output logic                    flush,
    output logic [`CORE_XLEN-1:0]   redirect_pc,
    output logic                    halt,
    output logic                    exit,
    output logic [`CORE_XLEN-1:0]   gp,
    output logic [`CORE_REG_AW-1:0] wb_rd,
    output logic                    wb_rf_wen
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];
    logic [`CORE_XLEN-1:0] wb_data;
    logic                  is_ecall;

    always_comb begin
        case (mw.ctrl.wb_sel)
            core_pkg::WB_MEM:      wb_data = mw.rdata;
            core_pkg::WB_PC_PLUS4: wb_data = mw.pc + 32'd4;
            default:               wb_data = mw.alu_out;
        endcase
    end

    assign wb_rd     = mw.rd;
    assign wb_rf_wen = mw.ctrl.valid && mw.ctrl.rf_wen;

    // x0 never written
    always_ff @(posedge clk) begin
        if (wb_rf_wen && mw.rd != '0)
            regs[mw.rd] <= wb_data;
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign gp       = regs[`CORE_GP_REG];

    // ecall also kills everything younger, so nothing issues behind it
    assign is_ecall    = mw.ctrl.valid && mw.ctrl.is_ecall;
    assign flush       = is_ecall || (mw.ctrl.valid && mw.br_taken);
    assign redirect_pc = mw.br_target;
    assign halt        = exit || is_ecall;

    always_ff @(posedge clk) begin
        if (reset)
            exit <= 1'b0;
        else if (is_ecall)
            exit <= 1'b1;
    end

endmodule

/* core.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module core (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  inst_start,
    output logic [`CORE_XLEN-1:0] i_addr,
    input  logic                  inst_ready,
    input  logic [`CORE_XLEN-1:0] inst,
    input  logic                  inst_valid,
    output logic                  d_cmd_start,
    output logic                  d_cmd_write,
    output logic [`CORE_XLEN-1:0] d_addr,
    output logic [`CORE_XLEN-1:0] wdata,
    output logic [`CORE_XLEN-1:0] wmask,
    input  logic                  d_cmd_ready,
    input  logic [`CORE_XLEN-1:0] rdata,
    input  logic                  rdata_valid,
    output logic                  exit,
    output logic [`CORE_XLEN-1:0] gp
);

    logic                    mem_stall;
    logic                    hazard_stall;
    logic                    flush;
    logic                    halt;
    logic [`CORE_XLEN-1:0]   redirect_pc;
    logic                    id_valid;
    logic [`CORE_XLEN-1:0]   id_pc;
    logic [`CORE_XLEN-1:0]   id_inst;
    logic [`CORE_REG_AW-1:0] rs1_addr;
    logic [`CORE_REG_AW-1:0] rs2_addr;
    logic [`CORE_XLEN-1:0]   rs1_data;
    logic [`CORE_XLEN-1:0]   rs2_data;
    logic [`CORE_REG_AW-1:0] ex_rd;
    logic                    ex_rf_wen;
    logic [`CORE_REG_AW-1:0] mem_rd;
    logic                    mem_rf_wen;
    logic [`CORE_REG_AW-1:0] wb_rd;
    logic                    wb_rf_wen;

    decode_exec_if de_bus ();
    exec_mem_if    em_bus ();
    mem_wb_if      mw_bus ();

    // ******************************
    // fetch and decode
    // ******************************
    fetch_stage u_fetch (
        .clk, .reset,
        .stall        (mem_stall),
        .hazard_stall, .flush, .redirect_pc, .halt,
        .inst_start, .i_addr, .inst_ready, .inst, .inst_valid,
        .id_valid, .id_pc, .id_inst
    );

    decode_stage u_decode (
        .clk, .reset,
        .id_valid, .id_pc, .id_inst,
        .stall        (mem_stall),
        .flush,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .hazard_stall,
        .ex_rd, .ex_rf_wen, .mem_rd, .mem_rf_wen, .wb_rd, .wb_rf_wen,
        .de           (de_bus)
    );

    // ******************************
    // execute, memory, writeback
    // ******************************
    execute_stage u_execute (
        .clk, .reset,
        .stall        (mem_stall),
        .flush,
        .de           (de_bus),
        .em           (em_bus),
        .ex_rd, .ex_rf_wen
    );

    memory_stage u_memory (
        .clk, .reset, .flush,
        .em           (em_bus),
        .mw           (mw_bus),
        .mem_stall,
        .d_cmd_start, .d_cmd_write, .d_addr, .wdata, .wmask,
        .d_cmd_ready, .rdata, .rdata_valid,
        .mem_rd, .mem_rf_wen
    );

    writeback_stage u_writeback (
        .clk, .reset,
        .mw           (mw_bus),
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .flush, .redirect_pc, .halt, .exit, .gp,
        .wb_rd, .wb_rf_wen
    );

endmodule

/* tb_core.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module tb_core;

    localparam int VEC_WORDS    = 256;
    localparam int IMEM_WORDS   = 64;
    localparam int DMEM_WORDS   = 256;
    localparam int RESET_CYCLES = 16;
    // cycles watched after exit for stray requests
    localparam int DRAIN_CYCLES = 20;

    logic                  clk;
    logic                  reset;
    logic                  inst_start;
    logic [`CORE_XLEN-1:0] i_addr;
    logic                  inst_ready;
    logic [`CORE_XLEN-1:0] inst;
    logic                  inst_valid;
    logic                  d_cmd_start;
    logic                  d_cmd_write;
    logic [`CORE_XLEN-1:0] d_addr;
    logic [`CORE_XLEN-1:0] wdata;
    logic [`CORE_XLEN-1:0] wmask;
    logic                  d_cmd_ready;
    logic [`CORE_XLEN-1:0] rdata;
    logic                  rdata_valid;
    logic                  exit;
    logic [`CORE_XLEN-1:0] gp;

    logic [31:0] vec  [VEC_WORDS];
    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];

    int          prog_len;
    int          store_cnt;
    logic [31:0] exp_gp;
    int          errors;
    int          checks;
    int          fetches;
    int          stores;
    logic [31:0] rng;

    // instruction port model
    logic        i_armed;
    int          i_ready_cnt;
    logic        i_busy;
    int          i_wait;
    logic [31:0] i_word;

    // data port model
    logic        d_armed;
    int          d_ready_cnt;
    logic        d_busy;
    int          d_wait;
    logic [31:0] d_word;

    core u_dut (
        .clk, .reset,
        .inst_start, .i_addr, .inst_ready, .inst, .inst_valid,
        .d_cmd_start, .d_cmd_write, .d_addr, .wdata, .wmask,
        .d_cmd_ready, .rdata, .rdata_valid,
        .exit, .gp
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // untouched data words carry their own address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ 32'hd5a5_0000;
    endfunction

    task automatic draw_delay(output int delay);
        rng   = xorshift(rng);
        delay = int'(rng[1:0]);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR: %s", what);
    endtask

    // next expected record, in program order
    task automatic check_store();
        int base;
        base = 3 + prog_len + 3 * stores;
        if (stores >= store_cnt) begin
            report_error($sformatf("unexpected store of %h to %h", wdata, d_addr));
        end else begin
            if (d_addr !== vec[base])
                report_mismatch($sformatf("store %0d address", stores), vec[base], d_addr);
            if (wdata !== vec[base + 1])
                report_mismatch($sformatf("store %0d data", stores), vec[base + 1], wdata);
            if (wmask !== vec[base + 2])
                report_mismatch($sformatf("store %0d mask", stores), vec[base + 2], wmask);
        end
        stores++;
    endtask

    // ******************************
    // memory models, run on the falling edge
    // ******************************
    task automatic serve_fetch();
        inst_valid = 1'b0;
        if (i_busy) begin
            i_wait--;
            if (i_wait == 0) begin
                inst       = i_word;
                inst_valid = 1'b1;
                i_busy     = 1'b0;
            end
        end
        if (!inst_start) begin
            inst_ready = 1'b0;
            i_armed    = 1'b0;
        end else begin
            if (!i_armed) begin
                i_armed = 1'b1;
                draw_delay(i_ready_cnt);
            end
            if (i_ready_cnt > 0) begin
                inst_ready = 1'b0;
                i_ready_cnt--;
            end else begin
                // taken at the coming rising edge
                inst_ready = 1'b1;
                i_armed    = 1'b0;
                checks++;
                if (exit)
                    report_error("instruction request accepted after exit");
                if (fetches == 0 && i_addr !== `CORE_RESET_PC)
                    report_mismatch("first fetch address", `CORE_RESET_PC, i_addr);
                if (i_addr[31:2] < IMEM_WORDS)
                    i_word = imem[i_addr[31:2]];
                else
                    i_word = 32'h0000_0013;
                draw_delay(i_wait);
                i_wait++;
                i_busy = 1'b1;
                fetches++;
            end
        end
    endtask

    task automatic serve_data();
        logic in_range;
        rdata_valid = 1'b0;
        if (d_busy) begin
            d_wait--;
            if (d_wait == 0) begin
                rdata       = d_word;
                rdata_valid = 1'b1;
                d_busy      = 1'b0;
            end
        end
        if (!d_cmd_start) begin
            d_cmd_ready = 1'b0;
            d_armed     = 1'b0;
        end else begin
            if (!d_armed) begin
                d_armed = 1'b1;
                draw_delay(d_ready_cnt);
            end
            if (d_ready_cnt > 0) begin
                d_cmd_ready = 1'b0;
                d_ready_cnt--;
            end else begin
                d_cmd_ready = 1'b1;
                d_armed     = 1'b0;
                in_range    = (d_addr < DMEM_WORDS * 4) && (d_addr[1:0] == 2'b00);
                checks++;
                if (exit)
                    report_error("data command accepted after exit");
                if (!in_range)
                    report_error($sformatf("data access to %h is outside memory", d_addr));
                if (d_cmd_write) begin
                    check_store();
                    if (in_range)
                        dmem[d_addr[9:2]] = wdata;
                end else begin
                    d_word = in_range ? dmem[d_addr[9:2]] : fill_word(d_addr);
                    draw_delay(d_wait);
                    d_wait++;
                    d_busy = 1'b1;
                end
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        int i;
        int cycles;
        int cycle_limit;
        int exit_cycle;

        reset       = 1'b1;
        inst_ready  = 1'b0;
        inst        = '0;
        inst_valid  = 1'b0;
        d_cmd_ready = 1'b0;
        rdata       = '0;
        rdata_valid = 1'b0;
        errors      = 0;
        checks      = 0;
        fetches     = 0;
        stores      = 0;
        rng         = 32'd24813;
        i_armed     = 1'b0;
        i_busy      = 1'b0;
        i_ready_cnt = 0;
        i_wait      = 0;
        i_word      = '0;
        d_armed     = 1'b0;
        d_busy      = 1'b0;
        d_ready_cnt = 0;
        d_wait      = 0;
        d_word      = '0;

        $readmemh("core_vectors.txt", vec);
        prog_len  = int'(vec[0]);
        store_cnt = int'(vec[1]);
        exp_gp    = vec[2];
        for (i = 0; i < IMEM_WORDS; i++)
            imem[i] = (i < prog_len) ? vec[3 + i] : 32'h0000_0013;
        for (i = 0; i < DMEM_WORDS; i++)
            dmem[i] = fill_word(i * 4);
        cycle_limit = 40 * prog_len + 200;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            checks++;
            if (inst_start !== 1'b0 || d_cmd_start !== 1'b0 || exit !== 1'b0)
                report_error("a start or exit output is not low during reset");
        end
        reset = 1'b0;

        // ******************************
        // run to exit, then watch a while
        // ******************************
        cycles     = 0;
        exit_cycle = -1;
        while (cycles < cycle_limit &&
               (exit_cycle < 0 || cycles < exit_cycle + DRAIN_CYCLES)) begin
            @(negedge clk);
            cycles++;
            if (exit === 1'b1 && exit_cycle < 0)
                exit_cycle = cycles;
            else if (exit_cycle >= 0 && exit !== 1'b1)
                report_error("exit dropped after it was raised");
            serve_fetch();
            serve_data();
        end

        if (exit_cycle < 0) begin
            report_error($sformatf("the core never raised exit within %0d cycles", cycle_limit));
        end else begin
            checks++;
            if (gp !== exp_gp)
                report_mismatch("final gp", exp_gp, gp);
            checks++;
            if (stores != store_cnt)
                report_mismatch("store count", store_cnt, stores);
        end

        $display("checks: %0d, errors: %0d, fetches: %0d, stores: %0d",
                 checks, errors, fetches, stores);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* core_vectors.txt */
// header: program length and store count (hex), expected gp
// then the program words, then one store per line: address data mask
00000023 00000009 1234574c
// 0x00 addi x1,x0,256 / addi x2,x0,5 / addi x4,x0,-3 / add x5,x2,x4
10000093 00500113 ffd00213 004102b3
// 0x10 sw x5,0(x1) / sub x6,x2,x4 / sw x6,4(x1) / lui x7,0x12345
0050a023 40410333 0060a223 123453b7
// 0x20 ori x7,x7,0x678 / sw x7,8(x1) / xori x8,x7,-1 / xor x9,x8,x2
6783e393 0070a423 fff3c413 002444b3
// 0x30 slt x10,x4,x2 / sw x9,12(x1) / sw x10,16(x1) / andi x11,x7,0xf0
00222533 0090a623 00a0a823 0f03f593
// 0x40 lw x12,8(x1) / add x13,x12,x11 / sw x13,20(x1) / beq x2,x5 not taken
0080a603 00b606b3 00d0aa23 00510663
// 0x50 sw x2,24(x1) / bne x2,x5 taken / shadow sw / shadow sw
0020ac23 00511663 0040ae23 0240a023
// 0x60 jal x14,+12 / shadow sw / shadow sw / sw x14,44(x1)
00c0076f 0240a223 0240a423 02e0a623
// 0x70 beq x13,x13 taken / shadow sw / bne x2,x2 not taken / add x3,x13,x14
00d68463 0240a823 00211463 00e681b3
// 0x80 sw x3,52(x1) / ecall / sw after ecall
0230aa23 00000073 0240ac23
// expected stores
00000100 00000002 ffffffff
00000104 00000008 ffffffff
00000108 12345678 ffffffff
0000010c edcba982 ffffffff
00000110 00000001 ffffffff
00000114 123456e8 ffffffff
00000118 00000005 ffffffff
0000012c 00000064 ffffffff
00000134 1234574c ffffffff

/* compile.f */
+incdir+.
core_pkg.sv
stage_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
writeback_stage.sv
core.sv
tb_core.sv

/* Bender.yml */
package:
  name: rv32i_pipe_core

sources:
  - include_dirs:
      - .
    files:
      - core_pkg.sv
      - stage_if.sv
      - fetch_stage.sv
      - decode_stage.sv
      - execute_stage.sv
      - memory_stage.sv
      - writeback_stage.sv
      - core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_core.sv
